// File: list.f
hdl/video_pkg.sv
hdl/cpu_write_if.sv
hdl/video_regs.sv
hdl/raster_timing.sv
hdl/tile_fetch.sv
hdl/colour_lookup.sv
hdl/video_top.sv
tests/video_tb.sv

// File: run.sh
#!/bin/sh
# builds the video engine testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -f list.f --top-module video_tb -o video_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/video_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
  exit 0
fi
echo "pass line missing from sim.log"
exit 1

// File: tests/video_tb.sv
`timescale 1ns/10ps

module video_tb;

  localparam int frame_pixels = video_pkg::h_visible * video_pkg::v_visible;
  // one frame is 87120 raster steps and random ready stretches that to about twice as long
  localparam int frame_timeout = 400000;
  localparam int line_timeout = 200000;

  logic            clk = 1'b0;
  logic            resetn;
  logic            cpu_valid;
  logic [3:0]      cpu_wstrb;
  logic [31:0]     cpu_addr;
  logic [31:0]     cpu_wdata;
  logic            pix_ready = 1'b1;
  logic            pix_valid;
  logic            pix_sof;
  video_pkg::rgb_t pix_rgb;
  logic            irq;

  // model memories that every cpu write lands in as well
  video_pkg::tile_entry_t map_m [2048];
  video_pkg::texel_t      tex_m [16384];
  video_pkg::subpal_t     sub_m [16];
  video_pkg::rgb_t        pal_m [16];
  logic [31:0]            scroll_m = '0;

  // memory fill and ready pattern each step their own copy of the lfsr
  logic [31:0] fill_lfsr = 32'h27cc_ec6d;
  logic [31:0] ready_lfsr = 32'h27cc_ec6d;
  logic        rand_ready = 1'b0;
  logic        check_en = 1'b0;

  // compare process state
  logic checking = 1'b0;
  logic first_seen = 1'b0;
  int   exp_x = 0;
  int   exp_y = 0;
  int   cur_xofs = 0;
  int   cur_yofs = 0;
  int   frame_pix = 0;
  int   sof_count = 0;
  int   irq_count = 0;

  video_top dut0 (
    .clk(clk), .resetn(resetn), .cpu_valid(cpu_valid), .cpu_wstrb(cpu_wstrb),
    .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata), .pix_ready(pix_ready),
    .pix_valid(pix_valid), .pix_sof(pix_sof), .pix_rgb(pix_rgb), .irq(irq)
  );

  always #4 clk = ~clk;

  // ------------------------------
  // helpers
  // ------------------------------

  // galois form of x^32 + x^22 + x^2 + x + 1 where the low bit is the one taken
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      fill_lfsr = lfsr_step(fill_lfsr);
      v = {v[30:0], fill_lfsr[0]};
    end
  endtask

  // region code goes in addr[23:20] and the word index in addr[15:2]
  function automatic logic [31:0] make_addr(input video_pkg::region_t r, input int word);
    return {8'h00, r, 4'h0, 14'(word), 2'b00};
  endfunction

  // stimulus always moves one ns past the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    $display("TEST FAILED");
    $fatal(1, "wait loop ran out of cycles");
  endtask

  // one write cycle where the model follows the byte lane rules of each region
  task automatic cpu_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    logic [13:0] word;
    word = addr[15:2];
    cpu_valid = 1'b1;
    cpu_addr = addr;
    cpu_wdata = data;
    cpu_wstrb = strb;
    case (video_pkg::region_t'(addr[23:20]))
      video_pkg::region_config: begin
        if (word == 14'(video_pkg::reg_scroll)) begin
          if (strb[0]) scroll_m[7:0] = data[7:0];
          if (strb[1]) scroll_m[15:8] = data[15:8];
          if (strb[2]) scroll_m[23:16] = data[23:16];
          if (strb[3]) scroll_m[31:24] = data[31:24];
        end
      end
      video_pkg::region_texture: if (strb[0]) tex_m[word] = data[1:0];
      video_pkg::region_tilemap: if (strb[0]) map_m[word[10:0]] = data[11:0];
      video_pkg::region_palette: if (strb[0]) pal_m[word[3:0]] = data[5:0];
      video_pkg::region_subpal: begin
        if (strb[0]) sub_m[word[3:0]][7:0] = data[7:0];
        if (strb[1]) sub_m[word[3:0]][15:8] = data[15:8];
      end
      default: ;
    endcase
    tick();
    cpu_valid = 1'b0;
  endtask

  task automatic wait_frames(input int n);
    int target;
    int cycles;
    target = sof_count + n;
    cycles = 0;
    while (sof_count < target && cycles < n * frame_timeout) begin
      tick();
      cycles++;
    end
    if (sof_count < target) report_timeout("a frame start on the pixel stream");
  endtask

  task automatic wait_line(input int line);
    int cycles;
    cycles = 0;
    while (exp_y < line && cycles < line_timeout) begin
      tick();
      cycles++;
    end
    if (exp_y < line) report_timeout("the pixel stream to reach a line");
  endtask

  // returns once the last visible pixel has left and the raster is in the final hblank
  task automatic wait_last_pixel();
    int cycles;
    cycles = 0;
    while (frame_pix < frame_pixels && cycles < frame_timeout) begin
      tick();
      cycles++;
    end
    if (frame_pix < frame_pixels) report_timeout("the last pixel of a frame");
  endtask

  // ------------------------------
  // reference and compare tasks
  // ------------------------------

  // the scrolled position picks a tile cell and the texel picks a sub-palette nibble
  function automatic video_pkg::rgb_t ref_pixel(input int x, input int y,
                                                input int xo, input int yo);
    int                     ex;
    int                     ey;
    video_pkg::tile_entry_t entry;
    video_pkg::texel_t      t;
    video_pkg::colour_idx_t idx;
    ex = (x + xo) % 512;
    ey = (y + yo) % 256;
    entry = map_m[11'((ey / 8) * 64 + ex / 8)];
    t = tex_m[14'(int'(entry.tile) * 64 + (ey % 8) * 8 + ex % 8)];
    idx = sub_m[entry.subpal][4 * int'(t) +: 4];
    return pal_m[idx];
  endfunction

  task automatic check_pixel(input int x, input int y, input video_pkg::rgb_t got,
                             input video_pkg::rgb_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: pixel (%0d,%0d) is %h, expected %h", $time, x, y, got, exp);
      $display("TEST FAILED");
      $fatal(1, "pixel mismatch");
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
      $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1, "count mismatch");
    end
  endtask

  // ------------------------------
  // ready driver and compare
  // ------------------------------

  always @(posedge clk) begin
    #1;
    if (rand_ready) begin
      ready_lfsr = lfsr_step(ready_lfsr);
      pix_ready = ready_lfsr[0];
    end else begin
      pix_ready = 1'b1;
    end
  end

  // sampled at the falling edge where inputs and outputs have settled
  always @(negedge clk) begin
    if (irq) irq_count++;
    if (resetn && pix_valid && pix_ready) begin
      if (!first_seen) check_flag("sof of first pixel", pix_sof, 1'b1);
      first_seen = 1'b1;
      if (pix_sof) begin
        if (checking) check_count("pixels per frame", frame_pix, frame_pixels);
        // offsets were taken in the blanking just before this frame
        checking = check_en;
        cur_xofs = int'(scroll_m[8:0]);
        cur_yofs = int'(scroll_m[23:16]);
        frame_pix = 0;
        exp_x = 0;
        exp_y = 0;
        sof_count++;
      end
      if (checking) begin
        check_flag("pix_sof", pix_sof, exp_x == 0 && exp_y == 0);
        check_pixel(exp_x, exp_y, pix_rgb, ref_pixel(exp_x, exp_y, cur_xofs, cur_yofs));
      end
      frame_pix++;
      if (exp_x == video_pkg::h_visible - 1) begin
        exp_x = 0;
        exp_y = (exp_y == video_pkg::v_visible - 1) ? 0 : exp_y + 1;
      end else begin
        exp_x++;
      end
    end
  end

  // ------------------------------
  // stimulus
  // ------------------------------

  initial begin
    logic [31:0] r;
    int          irq_start;
    resetn = 1'b0;
    cpu_valid = 1'b0;
    cpu_wstrb = '0;
    cpu_addr = '0;
    cpu_wdata = '0;
    repeat (16) begin
      tick();
      check_flag("pix_valid during reset", pix_valid, 1'b0);
      check_flag("irq during reset", irq, 1'b0);
    end
    resetn = 1'b1;
    tick();
    check_flag("pix_valid right after reset", pix_valid, 1'b0);
    check_flag("irq right after reset", irq, 1'b0);
    irq_start = irq_count;

    // random contents for every memory while the first frame runs unchecked
    for (int i = 0; i < 16; i++) begin
      take_bits(6, r);
      cpu_write(make_addr(video_pkg::region_palette, i), r, 4'b0001);
      take_bits(16, r);
      cpu_write(make_addr(video_pkg::region_subpal, i), r, 4'b0011);
    end
    for (int i = 0; i < 2048; i++) begin
      take_bits(12, r);
      cpu_write(make_addr(video_pkg::region_tilemap, i), r, 4'b0001);
    end
    for (int i = 0; i < 16384; i++) begin
      take_bits(2, r);
      cpu_write(make_addr(video_pkg::region_texture, i), r, 4'b0001);
    end

    // a whole frame on zero offsets
    wait_frames(1);
    check_en = 1'b1;
    wait_frames(2);
    check_count("irq pulses with line 255", irq_count - irq_start, 0);

    // a mid-frame scroll write where both offsets wrap inside the visible area
    wait_line(100);
    cpu_write(make_addr(video_pkg::region_config, video_pkg::reg_scroll),
              {8'h00, 8'hc5, 7'h00, 9'h1f3}, 4'b1111);
    wait_frames(2);

    // partial strobes touch only the upper sub-palette byte and the y offset
    wait_last_pixel();
    take_bits(32, r);
    cpu_write(make_addr(video_pkg::region_subpal, 5), r, 4'b0010);
    take_bits(32, r);
    cpu_write(make_addr(video_pkg::region_config, video_pkg::reg_scroll), r, 4'b0100);
    wait_frames(2);

    // line 100 is entered once per frame
    cpu_write(make_addr(video_pkg::region_config, video_pkg::reg_irq_line), 32'd100, 4'b0011);
    wait_frames(1);
    irq_start = irq_count;
    wait_frames(3);
    check_count("irq pulses over three frames", irq_count - irq_start, 3);

    // back-pressure from the sink
    rand_ready <= 1'b1;
    wait_frames(2);
    rand_ready <= 1'b0;

    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: hdl/video_top.sv
`timescale 1ns/10ps

module video_top (
  input  logic            clk,
  input  logic            resetn,
  input  logic            cpu_valid,
  input  logic [3:0]      cpu_wstrb,
  input  logic [31:0]     cpu_addr,
  input  logic [31:0]     cpu_wdata,
  input  logic            pix_ready,
  output logic            pix_valid,
  output logic            pix_sof,
  output video_pkg::rgb_t pix_rgb,
  output logic            irq
);

  cpu_write_if cpu_bus ();

  logic                   advance;
  logic                   visible;
  logic                   sof;
  logic                   vblank;
  logic                   fetch_valid;
  logic                   fetch_sof;
  video_pkg::xpos_t       x;
  video_pkg::ypos_t       y;
  video_pkg::xofs_t       xofs;
  video_pkg::yofs_t       yofs;
  video_pkg::ypos_t       irq_line;
  video_pkg::texel_t      texel;
  video_pkg::colour_idx_t subpal_sel;

  // plain cpu ports fan out to every storage block through the bus
  assign cpu_bus.valid = cpu_valid;
  assign cpu_bus.wstrb = cpu_wstrb;
  assign cpu_bus.addr = cpu_addr;
  assign cpu_bus.wdata = cpu_wdata;

  // ------------------------------
  // pipeline stall
  // ------------------------------

  // the whole pipe including the raster moves when the output slot can take a pixel
  assign advance = !pix_valid || pix_ready;

  video_regs regs0 (
    .clk(clk), .resetn(resetn), .cpu(cpu_bus), .advance(advance), .vblank(vblank),
    .xofs(xofs), .yofs(yofs), .irq_line(irq_line)
  );

  raster_timing raster0 (
    .clk(clk), .resetn(resetn), .advance(advance), .irq_line(irq_line),
    .x(x), .y(y), .visible(visible), .sof(sof), .vblank(vblank), .irq(irq)
  );

  // two stages of memory reads, then one stage of colour lookup
  tile_fetch fetch0 (
    .clk(clk), .resetn(resetn), .cpu(cpu_bus), .advance(advance),
    .x(x), .y(y), .visible(visible), .sof(sof), .xofs(xofs), .yofs(yofs),
    .texel(texel), .subpal_sel(subpal_sel), .out_valid(fetch_valid), .out_sof(fetch_sof)
  );

  colour_lookup lookup0 (
    .clk(clk), .resetn(resetn), .cpu(cpu_bus), .advance(advance),
    .texel(texel), .subpal_sel(subpal_sel), .in_valid(fetch_valid), .in_sof(fetch_sof),
    .pix_valid(pix_valid), .pix_sof(pix_sof), .pix_rgb(pix_rgb)
  );

endmodule

// File: hdl/colour_lookup.sv
`timescale 1ns/10ps

module colour_lookup (
  input  logic                    clk,
  input  logic                    resetn,
  cpu_write_if.cpu_target         cpu,
  input  logic                    advance,
  input  video_pkg::texel_t       texel,
  input  video_pkg::colour_idx_t  subpal_sel,
  input  logic                    in_valid,
  input  logic                    in_sof,
  output logic                    pix_valid,
  output logic                    pix_sof,
  output video_pkg::rgb_t         pix_rgb
);

  // sixteen 4-colour sub-palettes pointing into a 16-entry global palette
  video_pkg::subpal_t sub_palette [16];
  video_pkg::rgb_t    palette [16];

  logic                   pal_sel;
  logic                   sub_sel;
  logic [3:0]             entry_idx;
  video_pkg::subpal_t     tile_subpal;
  video_pkg::colour_idx_t colour_idx;
  video_pkg::rgb_t        colour;

  assign entry_idx = cpu.addr[5:2];
  assign pal_sel = cpu.valid &&
                   (video_pkg::region_t'(cpu.addr[23:20]) == video_pkg::region_palette);
  assign sub_sel = cpu.valid &&
                   (video_pkg::region_t'(cpu.addr[23:20]) == video_pkg::region_subpal);

  // palette takes only the low six bits of lane 0, the sub-palette takes lanes 0 and 1
  always_ff @(posedge clk) begin
    if (pal_sel && cpu.wstrb[0]) begin
      palette[entry_idx] <= cpu.wdata[5:0];
    end
    if (sub_sel && cpu.wstrb[0]) begin
      sub_palette[entry_idx][7:0] <= cpu.wdata[7:0];
    end
    if (sub_sel && cpu.wstrb[1]) begin
      sub_palette[entry_idx][15:8] <= cpu.wdata[15:8];
    end
  end

  // texel n picks nibble n of the tile's sub-palette, which then indexes the palette
  assign tile_subpal = sub_palette[subpal_sel];
  assign colour_idx = tile_subpal[{texel, 2'b00} +: 4];
  assign colour = palette[colour_idx];

  // ------------------------------
  // output register
  // ------------------------------

  // the colour itself carries no reset, only the flags do
  always_ff @(posedge clk) begin
    if (advance) begin
      pix_rgb <= colour;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      pix_valid <= 1'b0;
      pix_sof <= 1'b0;
    end else if (advance) begin
      pix_valid <= in_valid;
      pix_sof <= in_sof;
    end
  end

endmodule

// File: hdl/tile_fetch.sv
`timescale 1ns/10ps

module tile_fetch (
  input  logic                    clk,
  input  logic                    resetn,
  cpu_write_if.cpu_target         cpu,
  input  logic                    advance,
  input  video_pkg::xpos_t        x,
  input  video_pkg::ypos_t        y,
  input  logic                    visible,
  input  logic                    sof,
  input  video_pkg::xofs_t        xofs,
  input  video_pkg::yofs_t        yofs,
  output video_pkg::texel_t       texel,
  output video_pkg::colour_idx_t  subpal_sel,
  output logic                    out_valid,
  output logic                    out_sof
);

  // 64x32 tile map and 256 textures of 8x8 texels
  video_pkg::tile_entry_t tilemap [2048];
  video_pkg::texel_t      texture [16384];

  logic                      map_we;
  logic                      tex_we;
  logic [8:0]                ex;
  logic [7:0]                ey;
  video_pkg::tilemap_addr_t  map_raddr;
  video_pkg::texture_addr_t  tex_raddr;

  // stage 1 results
  video_pkg::tile_entry_t    s1_entry;
  logic [2:0]                s1_fine_x;
  logic [2:0]                s1_fine_y;
  logic                      s1_valid;
  logic                      s1_sof;

  // both memories only need byte lane 0 of a write
  assign map_we = cpu.valid && cpu.wstrb[0] &&
                  (video_pkg::region_t'(cpu.addr[23:20]) == video_pkg::region_tilemap);
  assign tex_we = cpu.valid && cpu.wstrb[0] &&
                  (video_pkg::region_t'(cpu.addr[23:20]) == video_pkg::region_texture);

  // effective position in the tile map, wrapping at 512 and 256 by width
  assign ex = x[8:0] + xofs;
  assign ey = y[7:0] + yofs;

  // row of tiles in the high bits, column in the low bits
  assign map_raddr = {ey[7:3], ex[8:3]};

  // texture number, then the row and column inside the 8x8 tile
  assign tex_raddr = {s1_entry.tile, s1_fine_y, s1_fine_x};

  // ------------------------------
  // memory ports and payload
  // ------------------------------

  always_ff @(posedge clk) begin
    if (map_we) begin
      tilemap[cpu.addr[12:2]] <= video_pkg::tile_entry_t'(cpu.wdata[11:0]);
    end
    if (tex_we) begin
      texture[cpu.addr[15:2]] <= cpu.wdata[1:0];
    end
    if (advance) begin
      // stage 1 reads the map cell and keeps the fine bits for stage 2
      s1_entry <= tilemap[map_raddr];
      s1_fine_x <= ex[2:0];
      s1_fine_y <= ey[2:0];
      // stage 2 reads the texel and passes the sub-palette along
      texel <= texture[tex_raddr];
      subpal_sel <= s1_entry.subpal;
    end
  end

  // valid and sof ride alongside the data
  always_ff @(posedge clk) begin
    if (!resetn) begin
      s1_valid <= 1'b0;
      s1_sof <= 1'b0;
      out_valid <= 1'b0;
      out_sof <= 1'b0;
    end else if (advance) begin
      s1_valid <= visible;
      s1_sof <= sof;
      out_valid <= s1_valid;
      out_sof <= s1_sof;
    end
  end

endmodule

// File: hdl/raster_timing.sv
`timescale 1ns/10ps

module raster_timing (
  input  logic             clk,
  input  logic             resetn,
  input  logic             advance,
  input  video_pkg::ypos_t irq_line,
  output video_pkg::xpos_t x,
  output video_pkg::ypos_t y,
  output logic             visible,
  output logic             sof,
  output logic             vblank,
  output logic             irq
);

  video_pkg::xpos_t x_next;
  video_pkg::ypos_t y_next;
  logic             y_step;

  // ------------------------------
  // next raster position
  // ------------------------------

  // x runs 0..319, jumps to -40 and counts up to -1 before the next line
  always_comb begin
    x_next = x + 10'sd1;
    y_next = y;
    y_step = 1'b0;
    if (x == video_pkg::xpos_t'(video_pkg::h_visible - 1)) begin
      x_next = video_pkg::xpos_t'(-video_pkg::h_blank);
    end else if (x == -10'sd1) begin
      x_next = '0;
      y_step = 1'b1;
      // after the last visible line y drops into the two blank lines
      if (y == video_pkg::ypos_t'(video_pkg::v_visible - 1)) begin
        y_next = video_pkg::ypos_t'(-video_pkg::v_blank);
      end else begin
        y_next = y + 9'sd1;
      end
    end
  end

  // counters and irq only move when the pipeline moves
  always_ff @(posedge clk) begin
    if (!resetn) begin
      x <= '0;
      y <= '0;
      irq <= 1'b0;
    end else begin
      irq <= 1'b0;
      if (advance) begin
        x <= x_next;
        y <= y_next;
        // y is only compared on the step where it changes so the pulse fires once
        irq <= y_step && (y_next == irq_line);
      end
    end
  end

  // ------------------------------
  // position flags
  // ------------------------------

  // the sign bits mark blanking in either direction
  assign visible = !x[9] && !y[8];
  assign vblank = y[8];

  // first pixel of a frame
  assign sof = (x == '0) && (y == '0);

endmodule

// File: hdl/video_regs.sv
`timescale 1ns/10ps

module video_regs (
  input  logic                  clk,
  input  logic                  resetn,
  cpu_write_if.cpu_target       cpu,
  input  logic                  advance,
  input  logic                  vblank,
  output video_pkg::xofs_t      xofs,
  output video_pkg::yofs_t      yofs,
  output video_pkg::ypos_t      irq_line
);

  // two 32-bit registers, word 0 is scroll and word 1 is the interrupt line
  logic [31:0] cfg_q [2];

  logic        cfg_sel;
  logic [13:0] word_idx;

  assign word_idx = cpu.addr[15:2];
  assign cfg_sel = cpu.valid &&
                   (video_pkg::region_t'(cpu.addr[23:20]) == video_pkg::region_config);

  // scroll layout keeps x in [8:0] and y in [23:16]
  always_ff @(posedge clk) begin
    if (!resetn) begin
      cfg_q[video_pkg::reg_scroll] <= '0;
      cfg_q[video_pkg::reg_irq_line] <= 32'(video_pkg::irq_line_reset);
      xofs <= '0;
      yofs <= '0;
    end else begin
      // each enabled byte lane updates its own slice of the addressed word
      if (cfg_sel && (word_idx < 14'd2)) begin
        for (int k = 0; k < 4; k++) begin
          if (cpu.wstrb[k]) begin
            cfg_q[word_idx[0]][8*k +: 8] <= cpu.wdata[8*k +: 8];
          end
        end
      end
      // active offsets only follow the register while the raster is off screen
      if (advance && vblank) begin
        xofs <= cfg_q[video_pkg::reg_scroll][8:0];
        yofs <= cfg_q[video_pkg::reg_scroll][23:16];
      end
    end
  end

  // the interrupt line is used straight from the register
  assign irq_line = video_pkg::ypos_t'(cfg_q[video_pkg::reg_irq_line][8:0]);

endmodule

// File: hdl/cpu_write_if.sv
`timescale 1ns/10ps

// write-only cpu bus shared by all storage blocks of the video engine
interface cpu_write_if;

  // write strobe, one cycle per transfer and never stalled
  logic valid;

  // byte enables, lane k covers wdata[8k+7:8k]
  logic [3:0] wstrb;

  // addr[23:20] picks the region and addr[15:2] is the word index
  logic [31:0] addr;
  logic [31:0] wdata;

  // every storage block only listens to the bus
  modport cpu_target (
    input valid,
    input wstrb,
    input addr,
    input wdata
  );

endinterface

// File: hdl/video_pkg.sv
package video_pkg;

  // ------------------------------
  // raster geometry
  // ------------------------------

  // visible area and blanking, in pixels per line and lines per frame
  localparam int h_visible = 320;
  localparam int h_blank = 40;
  localparam int v_visible = 240;
  localparam int v_blank = 2;

  // the raster never reaches line 255, so the interrupt stays quiet after reset
  localparam int irq_line_reset = 255;

  // ------------------------------
  // cpu address map
  // ------------------------------

  // region code lives in addr[23:20]
  typedef enum logic [3:0] {
    region_config  = 4'h0,
    region_texture = 4'h1,
    region_tilemap = 4'h2,
    region_palette = 4'h4,
    region_subpal  = 4'h5
  } region_t;

  // word indices inside the config region
  localparam int reg_scroll = 0;
  localparam int reg_irq_line = 1;

  // raster coordinates go negative while blanking
  typedef logic signed [9:0] xpos_t;
  typedef logic signed [8:0] ypos_t;

  // scroll offsets wrap at the tile map size of 512x256
  typedef logic [8:0] xofs_t;
  typedef logic [7:0] yofs_t;

  // one tile map cell, the sub-palette sits above the texture number
  typedef struct packed {
    logic [3:0] subpal;
    logic [7:0] tile;
  } tile_entry_t;

  typedef logic [1:0] texel_t;
  typedef logic [10:0] tilemap_addr_t;
  typedef logic [13:0] texture_addr_t;

  // colour path types, the sub-palette packs four global palette indices
  typedef logic [3:0] colour_idx_t;
  typedef logic [15:0] subpal_t;
  typedef logic [5:0] rgb_t;

endpackage
